// ==== verilog/icache_pkg.sv ====
/*
 * shared widths and types for the read-only 4-way instruction cache
 * fixed 32-bit byte address, 16-byte lines, 2-beat 64-bit refill
 * set count is not here, it is the SET_BITS parameter of each module
 */
package icache_pkg;

    localparam int ADDR_W   = 32;
    localparam int OFFSET_W = 4;     // byte offset in a line
    localparam int LINE_W   = 128;
    localparam int BEAT_W   = 64;
    localparam int NUM_WAYS = 4;

    // burst length in beats minus one, always two beats per line
    localparam logic [7:0] BURST_LEN = 8'd1;

    typedef logic [1:0] way_t;

    // cpu fetch request
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } cpu_req_t;

    // refill request toward memory
    typedef struct packed {
        logic [ADDR_W-1:0] addr;     // line aligned
        logic [7:0]        len;      // beats minus one
    } mem_req_t;

    // registered tag compare result
    typedef struct packed {
        logic [NUM_WAYS-1:0] hit_vec;
        way_t                hit_way;
    } lookup_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL,
        RESPOND
    } ctrl_state_e;

endpackage

// ==== verilog/icache_tag_store.sv ====
/*
 * tag and valid storage, one entry per set and way
 * lookup_o is registered, it reflects index_i and tag_i of the previous cycle
 * flush_i clears all valid bits in one cycle, tags are left as they are
 */
`timescale 1ns/1ps

module icache_tag_store #(
    parameter int SET_BITS = 7
) (
    input  logic                                                     clk,
    input  logic                                                     rst,
    input  logic [SET_BITS-1:0]                                      index_i,
    input  logic [icache_pkg::ADDR_W-icache_pkg::OFFSET_W-SET_BITS-1:0] tag_i,
    input  logic                                                     wr_en_i,
    input  icache_pkg::way_t                                         wr_way_i,
    input  logic                                                     flush_i,
    output icache_pkg::lookup_t                                      lookup_o
);

    localparam int SETS  = 1 << SET_BITS;
    localparam int TAG_W = icache_pkg::ADDR_W - icache_pkg::OFFSET_W - SET_BITS;

    logic [TAG_W-1:0]                tags_q  [icache_pkg::NUM_WAYS][SETS];
    logic [icache_pkg::NUM_WAYS-1:0] valid_q [SETS];

    logic [icache_pkg::NUM_WAYS-1:0] hit_vec;
    icache_pkg::way_t                hit_way;

    // compare all ways at once
    always_comb begin
        hit_vec = '0;
        hit_way = '0;
        for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
            hit_vec[w] = valid_q[index_i][w] && (tags_q[w][index_i] == tag_i);
            if (hit_vec[w]) begin
                hit_way = icache_pkg::way_t'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tags_q[wr_way_i][index_i] <= tag_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (wr_en_i) begin
            valid_q[index_i][wr_way_i] <= 1'b1;  // refilled way becomes valid
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lookup_o <= '0;
        end else begin
            lookup_o.hit_vec <= hit_vec;
            lookup_o.hit_way <= hit_way;
        end
    end

    // refill only targets a set that missed, so a tag never lives in two ways
    assert property (@(posedge clk) disable iff (rst) $onehot0(lookup_o.hit_vec))
        else $error("tag store: more than one way hit");

endmodule

// ==== verilog/icache_data_store.sv ====
/*
 * line storage, one 128-bit line per set and way
 * all four ways are read every cycle, output registered like the tag store
 * read during write of the same entry returns the old line
 */
`timescale 1ns/1ps

module icache_data_store #(
    parameter int SET_BITS = 7
) (
    input  logic                                                     clk,
    input  logic [SET_BITS-1:0]                                      index_i,
    input  logic                                                     wr_en_i,
    input  icache_pkg::way_t                                         wr_way_i,
    input  logic [icache_pkg::LINE_W-1:0]                            wr_line_i,
    output logic [icache_pkg::NUM_WAYS-1:0][icache_pkg::LINE_W-1:0]  way_lines_o
);

    localparam int SETS = 1 << SET_BITS;

    logic [icache_pkg::LINE_W-1:0] lines_q [icache_pkg::NUM_WAYS][SETS];

    always_ff @(posedge clk) begin
        for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
            if (wr_en_i && (wr_way_i == icache_pkg::way_t'(w))) begin
                lines_q[w][index_i] <= wr_line_i;  // refill write
            end
            way_lines_o[w] <= lines_q[w][index_i];
        end
    end

endmodule

// ==== verilog/icache_ctrl.sv ====
/*
 * cache controller, four-phase req/ack to the cpu, valid/ready/last burst to memory
 * req_i sampled high with the arrays read on one edge, hit or miss decided on the next
 * cpu_req_i must stay stable while req_i is high, it also drives the array index
 */
`timescale 1ns/1ps

module icache_ctrl #(
    parameter int SET_BITS = 7
) (
    input  logic                                                     clk,
    input  logic                                                     rst,
    input  logic                                                     req_i,
    input  icache_pkg::cpu_req_t                                     cpu_req_i,
    output logic                                                     ack_o,
    output logic [icache_pkg::LINE_W-1:0]                            data_o,
    input  icache_pkg::lookup_t                                      lookup_i,
    input  logic [icache_pkg::NUM_WAYS-1:0][icache_pkg::LINE_W-1:0]  way_lines_i,
    output logic [SET_BITS-1:0]                                      index_o,
    output logic [icache_pkg::ADDR_W-icache_pkg::OFFSET_W-SET_BITS-1:0] tag_o,
    output logic                                                     wr_en_o,
    output icache_pkg::way_t                                         wr_way_o,
    output logic [icache_pkg::LINE_W-1:0]                            wr_line_o,
    output logic                                                     mem_valid_o,
    output icache_pkg::mem_req_t                                     mem_req_o,
    input  logic                                                     mem_ready_i,
    input  logic                                                     mem_last_i,
    input  logic [icache_pkg::BEAT_W-1:0]                            mem_data_i,
    output logic [63:0]                                              hit_count_o,
    output logic [63:0]                                              miss_count_o
);

    localparam int TAG_W = icache_pkg::ADDR_W - icache_pkg::OFFSET_W - SET_BITS;

    icache_pkg::ctrl_state_e     state_q;
    icache_pkg::way_t            rr_q;       // round-robin victim
    logic [icache_pkg::BEAT_W-1:0] beat0_q;  // low half of the line

    logic hit;
    logic beat_fire;
    logic last_beat;

    assign index_o = cpu_req_i.addr[icache_pkg::OFFSET_W +: SET_BITS];
    assign tag_o   = cpu_req_i.addr[icache_pkg::ADDR_W-1 -: TAG_W];

    assign hit       = |lookup_i.hit_vec;
    assign beat_fire = (state_q == icache_pkg::REFILL) && mem_ready_i;
    assign last_beat = beat_fire && mem_last_i;

    // line goes into both stores on the edge that takes the last beat
    assign wr_en_o   = last_beat;
    assign wr_way_o  = rr_q;
    assign wr_line_o = {mem_data_i, beat0_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= icache_pkg::IDLE;
            ack_o        <= 1'b0;
            mem_valid_o  <= 1'b0;
            rr_q         <= '0;
            hit_count_o  <= '0;
            miss_count_o <= '0;
        end else begin
            case (state_q)
                icache_pkg::IDLE: begin
                    if (req_i) begin
                        state_q <= icache_pkg::LOOKUP;  // arrays read on this edge
                    end
                end
                icache_pkg::LOOKUP: begin
                    if (hit) begin
                        ack_o       <= 1'b1;
                        hit_count_o <= hit_count_o + 64'd1;
                        state_q     <= icache_pkg::RESPOND;
                    end else begin
                        mem_valid_o  <= 1'b1;
                        miss_count_o <= miss_count_o + 64'd1;
                        state_q      <= icache_pkg::REFILL;
                    end
                end
                icache_pkg::REFILL: begin
                    if (last_beat) begin
                        mem_valid_o <= 1'b0;
                        ack_o       <= 1'b1;
                        rr_q        <= rr_q + 2'd1;
                        state_q     <= icache_pkg::RESPOND;
                    end
                end
                icache_pkg::RESPOND: begin
                    if (!req_i) begin
                        ack_o   <= 1'b0;
                        state_q <= icache_pkg::IDLE;
                    end
                end
                default: state_q <= icache_pkg::IDLE;
            endcase
        end
    end

    // payload, held while nothing updates it
    always_ff @(posedge clk) begin
        if (state_q == icache_pkg::LOOKUP) begin
            if (hit) begin
                data_o <= way_lines_i[lookup_i.hit_way];
            end
            mem_req_o.addr <= {cpu_req_i.addr[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W],
                               {icache_pkg::OFFSET_W{1'b0}}};
            mem_req_o.len  <= icache_pkg::BURST_LEN;
        end
        if (beat_fire && !mem_last_i) begin
            beat0_q <= mem_data_i;
        end
        if (last_beat) begin
            data_o <= {mem_data_i, beat0_q};  // bypass straight to the cpu
        end
    end

    // ack only answers a request that is still up
    assert property (@(posedge clk) disable iff (rst) $rose(ack_o) |-> $past(req_i))
        else $error("ctrl: ack rose without req");

    assert property (@(posedge clk) disable iff (rst)
        mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_req_o))
        else $error("ctrl: mem request changed while stalled");

endmodule

// ==== verilog/icache_top.sv ====
/*
 * read-only 4-way instruction cache, 2**SET_BITS sets, SET_BITS >= 4
 * no writes, no coherence, flush_i only while req_i and ack_o are low
 */
`timescale 1ns/1ps

module icache_top #(
    parameter int SET_BITS = 7
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            req_i,
    input  icache_pkg::cpu_req_t            cpu_req_i,
    output logic                            ack_o,
    output logic [icache_pkg::LINE_W-1:0]   data_o,
    input  logic                            flush_i,
    output logic                            mem_valid_o,
    output icache_pkg::mem_req_t            mem_req_o,
    input  logic                            mem_ready_i,
    input  logic                            mem_last_i,
    input  logic [icache_pkg::BEAT_W-1:0]   mem_data_i,
    output logic [63:0]                     hit_count_o,
    output logic [63:0]                     miss_count_o
);

    localparam int TAG_W = icache_pkg::ADDR_W - icache_pkg::OFFSET_W - SET_BITS;

    logic [SET_BITS-1:0]                                     index;
    logic [TAG_W-1:0]                                        tag;
    logic                                                    wr_en;
    icache_pkg::way_t                                        wr_way;
    logic [icache_pkg::LINE_W-1:0]                           wr_line;
    icache_pkg::lookup_t                                     lookup;
    logic [icache_pkg::NUM_WAYS-1:0][icache_pkg::LINE_W-1:0] way_lines;

    icache_tag_store #(.SET_BITS(SET_BITS)) u_tag_store (
        .clk      (clk),
        .rst      (rst),
        .index_i  (index),
        .tag_i    (tag),
        .wr_en_i  (wr_en),
        .wr_way_i (wr_way),
        .flush_i  (flush_i),
        .lookup_o (lookup)
    );

    icache_data_store #(.SET_BITS(SET_BITS)) u_data_store (
        .clk         (clk),
        .index_i     (index),
        .wr_en_i     (wr_en),
        .wr_way_i    (wr_way),
        .wr_line_i   (wr_line),
        .way_lines_o (way_lines)
    );

    icache_ctrl #(.SET_BITS(SET_BITS)) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req_i        (req_i),
        .cpu_req_i    (cpu_req_i),
        .ack_o        (ack_o),
        .data_o       (data_o),
        .lookup_i     (lookup),
        .way_lines_i  (way_lines),
        .index_o      (index),
        .tag_o        (tag),
        .wr_en_o      (wr_en),
        .wr_way_o     (wr_way),
        .wr_line_o    (wr_line),
        .mem_valid_o  (mem_valid_o),
        .mem_req_o    (mem_req_o),
        .mem_ready_i  (mem_ready_i),
        .mem_last_i   (mem_last_i),
        .mem_data_i   (mem_data_i),
        .hit_count_o  (hit_count_o),
        .miss_count_o (miss_count_o)
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
/*
 * testbench clock and reset, 10 ns period
 * rst_o is high for the first 3 rising edges and is released with the third
 */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (3) @(posedge clk_o);
        rst_o <= 1'b0;  // synchronous release
    end

endmodule

// ==== testbench/icache_tb.sv ====
/*
 * testbench for icache_top, operations come from testbench/icache_input.txt
 * memory model returns {line address, beat number} in each 64-bit beat
 * must run from the project root so the data file path resolves
 */
`timescale 1ns/1ps

module icache_tb;

    localparam int SET_BITS  = 7;
    localparam int MAX_OPS   = 64;
    localparam int OP_CYCLES = 200;   // loose bound per operation, stalls included

    logic                 clk;
    logic                 rst;
    logic                 req;
    icache_pkg::cpu_req_t cpu_req;
    logic                 ack;
    logic [127:0]         data;
    logic                 flush;
    logic                 mem_valid;
    icache_pkg::mem_req_t mem_req;
    logic                 mem_ready = 1'b0;
    logic                 mem_last  = 1'b0;
    logic [63:0]          mem_data  = '0;
    logic [63:0]          hit_count;
    logic [63:0]          miss_count;

    logic [31:0] ops_mem [0:3*MAX_OPS-1];  // opcode, address, expected hit
    int          num_ops;
    logic        loaded = 1'b0;

    tb_clock_gen clock_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    icache_top #(.SET_BITS(SET_BITS)) icache_top_inst (
        .clk          (clk),
        .rst          (rst),
        .req_i        (req),
        .cpu_req_i    (cpu_req),
        .ack_o        (ack),
        .data_o       (data),
        .flush_i      (flush),
        .mem_valid_o  (mem_valid),
        .mem_req_o    (mem_req),
        .mem_ready_i  (mem_ready),
        .mem_last_i   (mem_last),
        .mem_data_i   (mem_data),
        .hit_count_o  (hit_count),
        .miss_count_o (miss_count)
    );

    // memory model, ready only once valid has been seen so the address is settled
    always @(posedge clk) begin
        if (mem_valid) begin
            check_value("refill burst length", 128'd1, 128'(mem_req.len));
        end
        if (rst || !mem_valid || (mem_ready && mem_last)) begin
            mem_ready <= 1'b0;
            mem_last  <= 1'b0;
            mem_data  <= '0;
        end else begin
            mem_last  <= mem_last | mem_ready;  // beat 0 taken, beat 1 next
            mem_data  <= {mem_req.addr, 31'd0, mem_last | mem_ready};
            mem_ready <= ($urandom % 4) != 0;   // random stalls
        end
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED %s expected %h actual %h",
                                        name, expected, actual));
        end
    endtask

    // one full four-phase fetch, called right after a rising edge
    task automatic fetch_line(input logic [31:0] addr, input logic exp_hit,
                              input string name);
        logic [63:0]  hits_before;
        logic [63:0]  misses_before;
        logic [31:0]  line_addr;
        logic [127:0] exp_line;
        line_addr     = {addr[31:4], 4'h0};
        exp_line      = {line_addr, 32'd1, line_addr, 32'd0};
        hits_before   = hit_count;
        misses_before = miss_count;
        req          <= 1'b1;
        cpu_req.addr <= addr;
        @(posedge clk);
        while (!ack) @(posedge clk);
        check_value({name, " line"}, exp_line, data);
        check_value({name, " mem_valid"}, '0, 128'(mem_valid));
        check_value({name, " hit count"}, 128'(exp_hit), 128'(hit_count - hits_before));
        check_value({name, " miss count"}, 128'(!exp_hit), 128'(miss_count - misses_before));
        req <= 1'b0;
        while (ack) @(posedge clk);
    endtask

    task automatic flush_cache();
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(posedge clk);
    endtask

    initial begin
        void'($urandom(87748));
        req     = 1'b0;
        cpu_req = '0;
        flush   = 1'b0;
        for (int i = 0; i < 3 * MAX_OPS; i++) begin
            ops_mem[i] = '1;  // anything above 1 ends the list
        end
        $readmemh("testbench/icache_input.txt", ops_mem);
        num_ops = 0;
        while (num_ops < MAX_OPS && ops_mem[3*num_ops] <= 1) num_ops++;
        loaded = 1'b1;
        if (num_ops == 0) begin
            stop_with_failure("no operations found in testbench/icache_input.txt");
        end

        while (rst !== 1'b0) @(posedge clk);
        check_value("reset ack and mem_valid", '0, 128'({ack, mem_valid}));
        check_value("reset hit count", '0, 128'(hit_count));
        check_value("reset miss count", '0, 128'(miss_count));

        for (int i = 0; i < num_ops; i++) begin
            if (ops_mem[3*i] == 32'd1) begin
                flush_cache();
            end else begin
                fetch_line(ops_mem[3*i+1], ops_mem[3*i+2][0],
                           $sformatf("op %0d fetch %h", i, ops_mem[3*i+1]));
            end
        end

        $display("all tests passed");
        $finish;
    end

    // watchdog
    initial begin
        wait (loaded);
        #((num_ops + 1) * OP_CYCLES * 10);
        stop_with_failure($sformatf("timeout, %0d operations did not finish in time",
                                    num_ops));
    end

endmodule

// ==== testbench/icache_input.txt ====
// columns: opcode (0 fetch, 1 flush), byte address, expected hit (1 hit, 0 miss)
// set 5 lines are 00000050 + n*00000800, round-robin pointer is shared by all sets
0 00000100 0
0 00000100 1
0 0000010c 1
0 00000050 0
0 00000850 0
0 00001050 0
0 00001850 0
0 00000054 1
0 00000850 1
0 0000105c 1
0 00001850 1
0 00002050 0
0 00000858 1
0 00001050 1
0 00001850 1
0 00002050 1
0 00000050 0
1 00000000 0
0 00000100 0
0 00000104 1
0 00000050 0
0 00000050 1
0 00001050 0
0 00001050 1
0 12345670 0
0 12345678 1

// ==== vlog.f ====
verilog/icache_pkg.sv
verilog/icache_tag_store.sv
verilog/icache_data_store.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
testbench/tb_clock_gen.sv
testbench/icache_tb.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := icache_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
PASS_MSG  := all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
